//--- common/demodParamsPkg.sv
// Demodulator parameters
// Widths, turn lengths, local oscillator table and gain trim constants
package demodParamsPkg;

    // ADC channels and sample format
    localparam int NUM_CHANNELS = 4;
    localparam int CHAN_WIDTH = $clog2(NUM_CHANNELS);
    localparam int ADC_WIDTH = 16;

    //////////////////////////////
    // local oscillator
    localparam int LO_WIDTH = 18;
    // amplitude of two to the LO_SHIFT keeps products exact
    localparam int LO_SHIFT = LO_WIDTH - 2;
    localparam int LO_PERIOD = 4;
    localparam int RAW_PRODUCT_WIDTH = ADC_WIDTH + LO_WIDTH;
    localparam logic signed [LO_WIDTH-1:0] LO_AMPLITUDE = 1 << LO_SHIFT;

    localparam logic signed [LO_WIDTH-1:0] LO_COS_TABLE [LO_PERIOD] = '{
        LO_AMPLITUDE, '0, -LO_AMPLITUDE, '0
    };
    localparam logic signed [LO_WIDTH-1:0] LO_SIN_TABLE [LO_PERIOD] = '{
        '0, LO_AMPLITUDE, '0, -LO_AMPLITUDE
    };

    //////////////////////////////
    // turn structure
    localparam int SAMPLES_PER_TURN = 8;
    localparam int PHASE_WIDTH = $clog2(SAMPLES_PER_TURN);
    localparam int TURNS_PER_RF_SUM = 4;
    localparam int TURN_COUNT_WIDTH = $clog2(TURNS_PER_RF_SUM);

    // accumulator limits
    localparam int SUM_WIDTH = 19;
    localparam logic signed [SUM_WIDTH-1:0] SUM_MAX = {1'b0, {(SUM_WIDTH-1){1'b1}}};
    localparam logic signed [SUM_WIDTH-1:0] SUM_MIN = {1'b1, {(SUM_WIDTH-1){1'b0}}};

    //////////////////////////////
    // magnitude and gain trim
    localparam int MAG_WIDTH = 20;
    localparam logic [MAG_WIDTH-1:0] MAG_MAX = '1;
    localparam int GAIN_WIDTH = 16;
    // unity gain is 16384
    localparam int GAIN_FRAC_BITS = 14;
    localparam int TRIM_PRODUCT_WIDTH = MAG_WIDTH + GAIN_WIDTH;

endpackage

//--- common/demodTypesPkg.sv
// Demodulator data types
// Sample, sum, magnitude and gain sets plus the tagged items of the magnitude path
package demodTypesPkg;

    typedef logic signed [demodParamsPkg::ADC_WIDTH-1:0] sampleT;
    typedef logic signed [demodParamsPkg::SUM_WIDTH-1:0] sumT;
    typedef logic [demodParamsPkg::MAG_WIDTH-1:0] magT;
    typedef logic [demodParamsPkg::GAIN_WIDTH-1:0] gainT;
    typedef logic [demodParamsPkg::CHAN_WIDTH-1:0] chanIdT;

    // one ADC sample per channel
    typedef struct packed {
        sampleT [demodParamsPkg::NUM_CHANNELS-1:0] ch;
    } adcSamplesT;

    typedef struct packed {
        sumT q;
        sumT i;
    } iqT;

    // mixer output at ADC scale
    typedef struct packed {
        iqT [demodParamsPkg::NUM_CHANNELS-1:0] ch;
    } productSetT;

    typedef struct packed {
        iqT [demodParamsPkg::NUM_CHANNELS-1:0] ch;
    } sumSetT;

    typedef struct packed {
        magT [demodParamsPkg::NUM_CHANNELS-1:0] ch;
    } magSetT;

    typedef struct packed {
        gainT [demodParamsPkg::NUM_CHANNELS-1:0] ch;
    } gainSetT;

    typedef enum logic {
        STREAM_TBT = 1'b0,
        STREAM_RF  = 1'b1
    } streamIdT;

    // one channel on its way through the magnitude estimator
    typedef struct packed {
        streamIdT stream;
        chanIdT channel;
        sumT q;
        sumT i;
    } magItemT;

    typedef struct packed {
        streamIdT stream;
        chanIdT channel;
        magT mag;
    } magResultT;

endpackage

//--- source/loSequencer.sv
`timescale 1ns/1ps
// Local oscillator sequencer
// Steps the sample phase of each turn and marks turn and RF interval ends
module loSequencer (
    input  logic clk,
    input  logic reset,
    output logic [demodParamsPkg::PHASE_WIDTH-1:0] phase,
    output logic turnEnd,
    output logic rfEnd
);

    logic [demodParamsPkg::TURN_COUNT_WIDTH-1:0] turnCount;

    // last sample of the turn
    assign turnEnd = (phase == demodParamsPkg::SAMPLES_PER_TURN - 1);

    // last turn of the RF interval
    assign rfEnd = turnEnd && (turnCount == demodParamsPkg::TURNS_PER_RF_SUM - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= '0;
            turnCount <= '0;
        end
        else if (turnEnd) begin
            phase <= '0;
            if (rfEnd) begin
                turnCount <= '0;
            end
            else begin
                turnCount <= turnCount + 1'b1;
            end
        end
        else begin
            phase <= phase + 1'b1;
        end
    end

endmodule

//--- source/demodMixer.sv
`timescale 1ns/1ps
// Demodulation mixer
// Registered I and Q products of every channel with the local oscillator
module demodMixer (
    input  logic clk,
    input  logic reset,
    input  demodTypesPkg::adcSamplesT adcSamples,
    input  logic [demodParamsPkg::PHASE_WIDTH-1:0] phase,
    input  logic turnEnd,
    input  logic rfEnd,
    output demodTypesPkg::productSetT products,
    output logic productTurnEnd,
    output logic productRfEnd
);

    logic signed [demodParamsPkg::LO_WIDTH-1:0] loCos;
    logic signed [demodParamsPkg::LO_WIDTH-1:0] loSin;
    logic signed [demodParamsPkg::RAW_PRODUCT_WIDTH-1:0] rawI [demodParamsPkg::NUM_CHANNELS];
    logic signed [demodParamsPkg::RAW_PRODUCT_WIDTH-1:0] rawQ [demodParamsPkg::NUM_CHANNELS];
    demodTypesPkg::productSetT nextProducts;

    // oscillator repeats twice per turn
    assign loCos = demodParamsPkg::LO_COS_TABLE[phase % demodParamsPkg::LO_PERIOD];
    assign loSin = demodParamsPkg::LO_SIN_TABLE[phase % demodParamsPkg::LO_PERIOD];

    always_comb begin
        for (int c = 0; c < demodParamsPkg::NUM_CHANNELS; c++) begin
            rawI[c] = $signed(adcSamples.ch[c]) * loCos;
            rawQ[c] = $signed(adcSamples.ch[c]) * loSin;
            // back to ADC scale
            nextProducts.ch[c].i = demodTypesPkg::sumT'(rawI[c] >>> demodParamsPkg::LO_SHIFT);
            nextProducts.ch[c].q = demodTypesPkg::sumT'(rawQ[c] >>> demodParamsPkg::LO_SHIFT);
        end
    end

    // boundary marks travel with the products
    always_ff @(posedge clk) begin
        if (reset) begin
            products <= '0;
            productTurnEnd <= 1'b0;
            productRfEnd <= 1'b0;
        end
        else begin
            products <= nextProducts;
            productTurnEnd <= turnEnd;
            productRfEnd <= rfEnd;
        end
    end

endmodule

//--- source/turnAccumulator.sv
`timescale 1ns/1ps
// Saturating I/Q accumulator
// Sums products over an interval and latches the sums at its last product
module turnAccumulator #(
    parameter int TURNS_PER_SUM = 1
) (
    input  logic clk,
    input  logic reset,
    input  demodTypesPkg::productSetT products,
    input  logic lastProduct,
    output demodTypesPkg::sumSetT sums,
    output logic sumsValid,
    output logic overflow
);

    demodTypesPkg::sumSetT acc;
    demodTypesPkg::sumSetT nextAcc;
    logic anySaturated;

    // returns {saturated, sum}
    function automatic logic [demodParamsPkg::SUM_WIDTH:0] satAdd(
        input demodTypesPkg::sumT a,
        input demodTypesPkg::sumT b
    );
        logic signed [demodParamsPkg::SUM_WIDTH:0] wide;
        wide = a + b;
        if (wide > demodParamsPkg::SUM_MAX) begin
            return {1'b1, demodParamsPkg::SUM_MAX};
        end
        if (wide < demodParamsPkg::SUM_MIN) begin
            return {1'b1, demodParamsPkg::SUM_MIN};
        end
        return {1'b0, wide[demodParamsPkg::SUM_WIDTH-1:0]};
    endfunction

    always_comb begin
        logic satI;
        logic satQ;
        anySaturated = 1'b0;
        for (int c = 0; c < demodParamsPkg::NUM_CHANNELS; c++) begin
            {satI, nextAcc.ch[c].i} = satAdd(acc.ch[c].i, products.ch[c].i);
            {satQ, nextAcc.ch[c].q} = satAdd(acc.ch[c].q, products.ch[c].q);
            anySaturated = anySaturated | satI | satQ;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
            sumsValid <= 1'b0;
            overflow <= 1'b0;
        end
        else begin
            sumsValid <= lastProduct;
            overflow <= anySaturated;
            if (lastProduct) begin
                acc <= '0;
            end
            else begin
                acc <= nextAcc;
            end
        end
    end

    // completed sums include the last product
    always_ff @(posedge clk) begin
        if (lastProduct) begin
            sums <= nextAcc;
        end
    end

endmodule

//--- magnitude/streamArbiter.sv
`timescale 1ns/1ps
// Stream arbiter
// Holds pending sum sets and feeds one channel per cycle, turn-by-turn first
module streamArbiter (
    input  logic clk,
    input  logic reset,
    input  demodTypesPkg::sumSetT tbtSums,
    input  logic tbtSumsValid,
    input  demodTypesPkg::sumSetT rfSums,
    input  logic rfSumsValid,
    output demodTypesPkg::magItemT item,
    output logic itemValid
);

    demodTypesPkg::sumSetT tbtCopy;
    demodTypesPkg::sumSetT rfCopy;
    demodTypesPkg::sumSetT activeSet;
    demodTypesPkg::streamIdT activeStream;
    demodTypesPkg::chanIdT channel;
    logic tbtPending;
    logic rfPending;
    logic busy;
    logic lastChannel;
    logic startTbt;
    logic startRf;

    assign lastChannel = (channel == demodParamsPkg::NUM_CHANNELS - 1);

    // next set may start while the last channel of the current one goes out
    assign startTbt = tbtPending && (!busy || lastChannel);
    assign startRf = rfPending && !tbtPending && (!busy || lastChannel);

    //////////////////////////////
    // sum set storage
    always_ff @(posedge clk) begin
        if (tbtSumsValid) begin
            tbtCopy <= tbtSums;
        end
        if (rfSumsValid) begin
            rfCopy <= rfSums;
        end
        if (startTbt) begin
            activeSet <= tbtCopy;
        end
        else if (startRf) begin
            activeSet <= rfCopy;
        end
    end

    //////////////////////////////
    // pending flags and channel walk
    always_ff @(posedge clk) begin
        if (reset) begin
            tbtPending <= 1'b0;
            rfPending <= 1'b0;
            busy <= 1'b0;
            channel <= '0;
            activeStream <= demodTypesPkg::STREAM_TBT;
        end
        else begin
            // newer set overwrites one not yet started
            tbtPending <= tbtSumsValid || (tbtPending && !startTbt);
            rfPending <= rfSumsValid || (rfPending && !startRf);
            if (startTbt || startRf) begin
                busy <= 1'b1;
                channel <= '0;
                activeStream <= startTbt ? demodTypesPkg::STREAM_TBT : demodTypesPkg::STREAM_RF;
            end
            else if (busy) begin
                channel <= channel + 1'b1;
                if (lastChannel) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    assign itemValid = busy;
    assign item.stream = activeStream;
    assign item.channel = channel;
    assign item.i = activeSet.ch[channel].i;
    assign item.q = activeSet.ch[channel].q;

endmodule

//--- magnitude/magnitudeEstimator.sv
`timescale 1ns/1ps
// Magnitude estimator
// Two-stage max plus half min approximation, tag carried alongside
module magnitudeEstimator (
    input  logic clk,
    input  logic reset,
    input  demodTypesPkg::magItemT item,
    input  logic itemValid,
    output demodTypesPkg::magResultT result,
    output logic resultValid
);

    logic [demodParamsPkg::SUM_WIDTH-1:0] absI;
    logic [demodParamsPkg::SUM_WIDTH-1:0] absQ;
    logic [demodParamsPkg::SUM_WIDTH-1:0] larger;
    logic [demodParamsPkg::SUM_WIDTH-1:0] smaller;
    demodTypesPkg::streamIdT stageStream;
    demodTypesPkg::chanIdT stageChannel;
    logic stageValid;

    assign larger = (absI >= absQ) ? absI : absQ;
    assign smaller = (absI >= absQ) ? absQ : absI;

    // stage 1 absolute values, stage 2 combine
    always_ff @(posedge clk) begin
        absI <= item.i[demodParamsPkg::SUM_WIDTH-1] ? -item.i : item.i;
        absQ <= item.q[demodParamsPkg::SUM_WIDTH-1] ? -item.q : item.q;
        stageStream <= item.stream;
        stageChannel <= item.channel;
        // half of the smaller, rounded down
        result.mag <= larger + (smaller >> 1);
        result.stream <= stageStream;
        result.channel <= stageChannel;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stageValid <= 1'b0;
            resultValid <= 1'b0;
        end
        else begin
            stageValid <= itemValid;
            resultValid <= stageValid;
        end
    end

endmodule

//--- magnitude/gainTrim.sv
`timescale 1ns/1ps
// Gain trim
// Scales each magnitude by its channel gain and assembles per-stream sets
module gainTrim (
    input  logic clk,
    input  logic reset,
    input  demodTypesPkg::magResultT result,
    input  logic resultValid,
    input  demodTypesPkg::gainSetT gains,
    output demodTypesPkg::magSetT tbtMags,
    output demodTypesPkg::magSetT rfMags,
    output logic tbtValid,
    output logic rfValid
);

    logic [demodParamsPkg::TRIM_PRODUCT_WIDTH-1:0] scaled;
    demodTypesPkg::magT trimmed;
    logic lastChannel;
    logic isTbt;

    // fixed point gain, GAIN_FRAC_BITS fraction bits
    assign scaled = (result.mag * gains.ch[result.channel]) >> demodParamsPkg::GAIN_FRAC_BITS;

    // clamp at full scale
    assign trimmed = (scaled > demodParamsPkg::MAG_MAX) ?
                     demodParamsPkg::MAG_MAX : scaled[demodParamsPkg::MAG_WIDTH-1:0];

    assign lastChannel = (result.channel == demodParamsPkg::NUM_CHANNELS - 1);
    assign isTbt = (result.stream == demodTypesPkg::STREAM_TBT);

    always_ff @(posedge clk) begin
        if (reset) begin
            tbtMags <= '0;
            rfMags <= '0;
            tbtValid <= 1'b0;
            rfValid <= 1'b0;
        end
        else begin
            // set is complete once channel 3 lands
            tbtValid <= resultValid && isTbt && lastChannel;
            rfValid <= resultValid && !isTbt && lastChannel;
            if (resultValid) begin
                if (isTbt) begin
                    tbtMags.ch[result.channel] <= trimmed;
                end
                else begin
                    rfMags.ch[result.channel] <= trimmed;
                end
            end
        end
    end

endmodule

//--- source/bpmProcessor.sv
`timescale 1ns/1ps
// BPM front end processing
// Demodulates four ADC channels into trimmed turn-by-turn and RF magnitudes
module bpmProcessor (
    input  logic clk,
    input  logic reset,
    input  demodTypesPkg::adcSamplesT adcSamples,
    input  demodTypesPkg::gainSetT gains,
    output demodTypesPkg::magSetT tbtMags,
    output demodTypesPkg::magSetT rfMags,
    output logic tbtValid,
    output logic rfValid,
    output logic overflowFlag
);

    logic [demodParamsPkg::PHASE_WIDTH-1:0] phase;
    logic turnEnd;
    logic rfEnd;
    demodTypesPkg::productSetT products;
    logic productTurnEnd;
    logic productRfEnd;
    demodTypesPkg::sumSetT tbtSums;
    demodTypesPkg::sumSetT rfSums;
    logic tbtSumsValid;
    logic rfSumsValid;
    logic tbtOverflow;
    logic rfOverflow;
    demodTypesPkg::magItemT item;
    logic itemValid;
    demodTypesPkg::magResultT result;
    logic resultValid;

    //////////////////////////////
    // demodulation
    loSequencer sequencer (.clk, .reset, .phase, .turnEnd, .rfEnd);

    demodMixer mixer (.clk, .reset, .adcSamples, .phase, .turnEnd, .rfEnd,
        .products, .productTurnEnd, .productRfEnd);

    turnAccumulator #(.TURNS_PER_SUM(1)) tbtAccumulator (.clk, .reset, .products,
        .lastProduct(productTurnEnd), .sums(tbtSums), .sumsValid(tbtSumsValid),
        .overflow(tbtOverflow));

    turnAccumulator #(.TURNS_PER_SUM(demodParamsPkg::TURNS_PER_RF_SUM)) rfAccumulator (
        .clk, .reset, .products, .lastProduct(productRfEnd), .sums(rfSums),
        .sumsValid(rfSumsValid), .overflow(rfOverflow));

    //////////////////////////////
    // shared magnitude path
    streamArbiter arbiter (.clk, .reset, .tbtSums, .tbtSumsValid, .rfSums, .rfSumsValid,
        .item, .itemValid);

    magnitudeEstimator estimator (.clk, .reset, .item, .itemValid, .result, .resultValid);

    gainTrim trim (.clk, .reset, .result, .resultValid, .gains, .tbtMags, .rfMags,
        .tbtValid, .rfValid);

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            overflowFlag <= 1'b0;
        end
        else if (tbtOverflow || rfOverflow) begin
            overflowFlag <= 1'b1;
        end
    end

endmodule

//--- verification/bpmProcessorChecker.sv
`timescale 1ns/1ps
// BPM processor output checker
// Concurrent assertions on valid pulses, the overflow flag and reset values
module bpmProcessorChecker (
    input logic clk,
    input logic reset,
    input demodTypesPkg::magSetT tbtMags,
    input demodTypesPkg::magSetT rfMags,
    input logic tbtValid,
    input logic rfValid,
    input logic overflowFlag
);

    // a set spans four channels so a stream never repeats on the next cycle
    tbtSpacing: assert property (@(posedge clk) disable iff (reset) tbtValid |=> !tbtValid)
        else $error("tbtValid high in two consecutive cycles");

    rfSpacing: assert property (@(posedge clk) disable iff (reset) rfValid |=> !rfValid)
        else $error("rfValid high in two consecutive cycles");

    // one result stream at a time
    validsExclusive: assert property (@(posedge clk) disable iff (reset) !(tbtValid && rfValid))
        else $error("tbtValid and rfValid high together");

    overflowSticky: assert property (@(posedge clk) disable iff (reset)
        overflowFlag |=> overflowFlag)
        else $error("overflowFlag fell while out of reset");

    // synchronous reset clears outputs one edge later
    resetValues: assert property (@(posedge clk) reset |=>
        (!tbtValid && !rfValid && !overflowFlag && tbtMags == '0 && rfMags == '0))
        else $error("outputs not cleared by reset");

endmodule

//--- verification/bpmProcessorTb.sv
`timescale 1ns/1ps
// BPM processor testbench
// Drives turns from a stimulus table and checks magnitudes against a reference model
module bpmProcessorTb;

    localparam int NUM_GROUPS = 8;
    localparam int NUM_ROWS = NUM_GROUPS * demodParamsPkg::TURNS_PER_RF_SUM;
    localparam int NUM_CH = demodParamsPkg::NUM_CHANNELS;
    localparam int TURN_LEN = demodParamsPkg::SAMPLES_PER_TURN;
    localparam int TIMEOUT_CYCLES = 4 + NUM_ROWS * TURN_LEN + 80;
    localparam longint SUM_HIGH = (longint'(1) << (demodParamsPkg::SUM_WIDTH - 1)) - 1;
    localparam longint SUM_LOW = -(longint'(1) << (demodParamsPkg::SUM_WIDTH - 1));
    localparam longint MAG_LIMIT = (longint'(1) << demodParamsPkg::MAG_WIDTH) - 1;
    localparam int UNITY = 1 << demodParamsPkg::GAIN_FRAC_BITS;

    // fixed rows of group 0
    localparam int FIXED_A [4][NUM_CH] = '{'{100, -200, 3000, 0}, '{-1500, 250, 7, 32000},
        '{12345, -12345, 1, -1}, '{0, 999, -4096, 20000}};
    localparam int FIXED_B [4][NUM_CH] = '{'{50, 400, -1000, -7}, '{1500, 0, -3, -31000},
        '{6789, 6789, -2, 2}, '{-8000, 0, 4096, -20000}};

    // oscillator sign per phase
    localparam int COS_SIGN [4] = '{1, 0, -1, 0};
    localparam int SIN_SIGN [4] = '{0, 1, 0, -1};

    logic clk;
    logic reset;
    demodTypesPkg::adcSamplesT adcSamples;
    demodTypesPkg::gainSetT gains;
    demodTypesPkg::magSetT tbtMags;
    demodTypesPkg::magSetT rfMags;
    logic tbtValid;
    logic rfValid;
    logic overflowFlag;

    //////////////////////////////
    // stimulus and expected table, one row per turn
    int rowA [NUM_ROWS][NUM_CH];
    int rowB [NUM_ROWS][NUM_CH];
    int rowGain [NUM_ROWS][NUM_CH];
    longint expTbt [NUM_ROWS][NUM_CH];
    longint expRf [NUM_GROUPS][NUM_CH];
    bit satUpTo [NUM_ROWS];
    int tbtCount;
    int rfCount;
    int cycleCount;

    bpmProcessor dut0 (.clk, .reset, .adcSamples, .gains, .tbtMags, .rfMags, .tbtValid,
        .rfValid, .overflowFlag);

    bind bpmProcessor bpmProcessorChecker checker0 (.clk, .reset, .tbtMags, .rfMags,
        .tbtValid, .rfValid, .overflowFlag);

    always #10 clk = ~clk;

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input longint expected, input longint actual);
        if (expected != actual) begin
            failRun($sformatf("CHECK FAILED %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    function automatic longint clampSum(input longint value);
        if (value > SUM_HIGH) begin
            return SUM_HIGH;
        end
        if (value < SUM_LOW) begin
            return SUM_LOW;
        end
        return value;
    endfunction

    // larger plus half the smaller
    function automatic longint magnitudeOf(input longint i, input longint q);
        longint absI;
        longint absQ;
        absI = (i < 0) ? -i : i;
        absQ = (q < 0) ? -q : q;
        if (absI >= absQ) begin
            return absI + absQ / 2;
        end
        return absQ + absI / 2;
    endfunction

    function automatic longint trimmed(input longint mag, input int gain);
        longint value;
        value = (mag * gain) >> demodParamsPkg::GAIN_FRAC_BITS;
        return (value > MAG_LIMIT) ? MAG_LIMIT : value;
    endfunction

    // a, b, -a, -b pattern
    function automatic int sampleAt(input int a, input int b, input int k);
        case (k % 4)
            0: return a;
            1: return b;
            2: return -a;
            default: return -b;
        endcase
    endfunction

    // new gains only after a silent group so that earlier results keep their own gains
    function automatic int gainFor(input int g, input int c);
        case (g / 2)
            1: return (c == 1) ? UNITY / 2 : ((c == 2) ? UNITY : 2 * UNITY);
            2: return (c < 2) ? 65535 : ((c == 2) ? 2 * UNITY : UNITY);
            default: return UNITY;
        endcase
    endfunction

    task automatic buildTable;
        int g;
        for (int r = 0; r < NUM_ROWS; r++) begin
            g = r / demodParamsPkg::TURNS_PER_RF_SUM;
            for (int c = 0; c < NUM_CH; c++) begin
                rowGain[r][c] = gainFor(g, c);
                case (g)
                    0: begin
                        rowA[r][c] = FIXED_A[r][c];
                        rowB[r][c] = FIXED_B[r][c];
                    end
                    // small enough that four turns never saturate
                    2: begin
                        rowA[r][c] = int'($urandom_range(32766)) - 16383;
                        rowB[r][c] = int'($urandom_range(32766)) - 16383;
                    end
                    4: begin
                        rowA[r][c] = 16000;
                        rowB[r][c] = -16000;
                    end
                    // full scale, RF sums saturate in the third turn
                    6: begin
                        rowA[r][c] = 32767;
                        rowB[r][c] = (c % 2 == 1) ? 32767 : -32767;
                    end
                    default: begin
                        rowA[r][c] = 0;
                        rowB[r][c] = 0;
                    end
                endcase
            end
        end
    endtask

    //////////////////////////////
    // reference model
    task automatic computeExpected;
        longint sumI [NUM_CH];
        longint sumQ [NUM_CH];
        longint nextI;
        longint nextQ;
        bit saturated;
        int s;
        saturated = 1'b0;
        for (int c = 0; c < NUM_CH; c++) begin
            sumI[c] = 0;
            sumQ[c] = 0;
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < NUM_CH; c++) begin
                expTbt[r][c] = trimmed(magnitudeOf(4 * rowA[r][c], 4 * rowB[r][c]),
                    rowGain[r][c]);
                for (int k = 0; k < TURN_LEN; k++) begin
                    s = sampleAt(rowA[r][c], rowB[r][c], k);
                    nextI = sumI[c] + s * COS_SIGN[k % 4];
                    nextQ = sumQ[c] + s * SIN_SIGN[k % 4];
                    sumI[c] = clampSum(nextI);
                    sumQ[c] = clampSum(nextQ);
                    saturated |= (sumI[c] != nextI) || (sumQ[c] != nextQ);
                end
            end
            satUpTo[r] = saturated;
            if (r % demodParamsPkg::TURNS_PER_RF_SUM == demodParamsPkg::TURNS_PER_RF_SUM - 1) begin
                for (int c = 0; c < NUM_CH; c++) begin
                    expRf[r / demodParamsPkg::TURNS_PER_RF_SUM][c] =
                        trimmed(magnitudeOf(sumI[c], sumQ[c]), rowGain[r][c]);
                    sumI[c] = 0;
                    sumQ[c] = 0;
                end
            end
        end
    endtask

    task automatic driveTurn(input int r);
        demodTypesPkg::adcSamplesT nextSamples;
        demodTypesPkg::gainSetT nextGains;
        for (int c = 0; c < NUM_CH; c++) begin
            nextGains.ch[c] = demodTypesPkg::gainT'(rowGain[r][c]);
        end
        for (int k = 0; k < TURN_LEN; k++) begin
            for (int c = 0; c < NUM_CH; c++) begin
                nextSamples.ch[c] = demodTypesPkg::sampleT'(sampleAt(rowA[r][c], rowB[r][c], k));
            end
            adcSamples <= nextSamples;
            gains <= nextGains;
            @(posedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        adcSamples = '0;
        gains = '0;
        tbtCount = 0;
        rfCount = 0;
        cycleCount = 0;
        void'($urandom(32'h9cff_8110));
        buildTable();
        computeExpected();
        // four edges with reset high
        repeat (4) @(posedge clk);
        // first turn starts at the releasing edge
        reset <= 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            driveTurn(r);
        end
        adcSamples <= '0;
        while (tbtCount < NUM_ROWS || rfCount < NUM_GROUPS) begin
            @(posedge clk);
        end
        @(negedge clk);
        checkValue("final overflowFlag", satUpTo[NUM_ROWS - 1], overflowFlag);
        $display("*** PASSED ***");
        $finish;
    end

    //////////////////////////////
    // output monitor, read half a cycle after the edge
    always @(negedge clk) begin
        if (!reset && tbtValid) begin
            if (tbtCount >= NUM_ROWS) begin
                failRun("tbtValid pulsed with no turn left to report");
            end
            else begin
                for (int c = 0; c < NUM_CH; c++) begin
                    checkValue($sformatf("tbt row %0d channel %0d", tbtCount, c),
                        expTbt[tbtCount][c], tbtMags.ch[c]);
                end
                // saturation in the following turn may or may not be visible yet
                if (satUpTo[tbtCount]) begin
                    checkValue($sformatf("overflowFlag at row %0d", tbtCount), 1, overflowFlag);
                end
                else if (tbtCount + 1 >= NUM_ROWS || !satUpTo[tbtCount + 1]) begin
                    checkValue($sformatf("overflowFlag at row %0d", tbtCount), 0, overflowFlag);
                end
                tbtCount++;
            end
        end
        if (!reset && rfValid) begin
            if (rfCount >= NUM_GROUPS) begin
                failRun("rfValid pulsed with no RF interval left to report");
            end
            else begin
                for (int c = 0; c < NUM_CH; c++) begin
                    checkValue($sformatf("rf group %0d channel %0d", rfCount, c),
                        expRf[rfCount][c], rfMags.ch[c]);
                end
                rfCount++;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            failRun($sformatf("timed out after %0d cycles waiting for results", cycleCount));
        end
    end

endmodule

//--- vlog.f
common/demodParamsPkg.sv
common/demodTypesPkg.sv
source/loSequencer.sv
source/demodMixer.sv
source/turnAccumulator.sv
magnitude/streamArbiter.sv
magnitude/magnitudeEstimator.sv
magnitude/gainTrim.sv
source/bpmProcessor.sv
verification/bpmProcessorChecker.sv
verification/bpmProcessorTb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the BPM processor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f \
    --top-module bpmProcessorTb \
    -Mdir build

# exit status of the simulation is the test result
./build/VbpmProcessorTb
